//--- hdl/core_regs_defs.svh
// width, register count and machine CSR address macros for the core register block
`ifndef CORE_REGS_DEFS_SVH
`define CORE_REGS_DEFS_SVH

// data word and index widths
`define CORE_XLEN   32
`define CORE_GPR_AW 5
`define CORE_CSR_AW 12

// machine trap setup
`define CSR_MSTATUS_ADDR  12'h300
`define CSR_MIE_ADDR      12'h304
`define CSR_MTVEC_ADDR    12'h305

// machine trap handling
`define CSR_MSCRATCH_ADDR 12'h340
`define CSR_MEPC_ADDR     12'h341
`define CSR_MCAUSE_ADDR   12'h342
`define CSR_MIP_ADDR      12'h344

// read-only user counters, high halves for rv32
`define CSR_CYCLE_ADDR    12'hc00
`define CSR_INSTRET_ADDR  12'hc02
`define CSR_CYCLEH_ADDR   12'hc80
`define CSR_INSTRETH_ADDR 12'hc82

`endif

//--- hdl/core_regs_pkg.sv
// core register block types: data word, addresses, interrupt codes, CSR word layouts
`include "core_regs_defs.svh"

package core_regs_pkg;

    typedef logic [`CORE_XLEN-1:0]   word_t;
    typedef logic [`CORE_GPR_AW-1:0] gpr_addr_t;
    typedef logic [`CORE_CSR_AW-1:0] csr_addr_t;

    // machine interrupt cause codes
    typedef enum logic [4:0] {
        irq_none = 5'd0,
        irq_msi  = 5'd3,
        irq_mti  = 5'd7,
        irq_mei  = 5'd11
    } irq_code_e;

    // machine-only view of mstatus
    typedef struct packed {
        logic [18:0] rsvd_31_13;
        logic [1:0]  mpp;
        logic [2:0]  rsvd_10_8;
        logic        mpie;
        logic [2:0]  rsvd_6_4;
        logic        mie;
        logic [2:0]  rsvd_2_0;
    } mstatus_t;

    // shared by mie and mip
    typedef struct packed {
        logic [19:0] rsvd_31_12;
        logic        meip;
        logic [2:0]  rsvd_10_8;
        logic        mtip;
        logic [2:0]  rsvd_6_4;
        logic        msip;
        logic [2:0]  rsvd_2_0;
    } irq_bits_t;

    typedef union packed {
        word_t     word;
        mstatus_t  mstatus;
        irq_bits_t irq;
    } csr_word_u;

endpackage

//--- hdl/csr_access_if.sv
// CSR access bus between the CSR file and its sub-units
`timescale 1ns/1ps

interface csr_access_if;

    logic                   wren;
    core_regs_pkg::csr_addr_t waddr;
    core_regs_pkg::word_t     wdata;
    core_regs_pkg::csr_addr_t raddr;

    modport owner (output wren, output waddr, output wdata, output raddr);

    // units decode their own addresses and return zero otherwise
    modport unit (input wren, input waddr, input wdata, input raddr);

endinterface

//--- hdl/gpr_file.sv
// integer register file, 32 words, two read ports, x0 zero and write bypass
`timescale 1ns/1ps
`include "core_regs_defs.svh"

module gpr_file (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      wren,
    input  core_regs_pkg::gpr_addr_t  waddr,
    input  core_regs_pkg::word_t      wdata,
    input  core_regs_pkg::gpr_addr_t  raddr1,
    input  core_regs_pkg::gpr_addr_t  raddr2,
    output core_regs_pkg::word_t      rdata1,
    output core_regs_pkg::word_t      rdata2
);

    localparam int NUM_REGS = 1 << `CORE_GPR_AW;

    core_regs_pkg::word_t regs [NUM_REGS];
    logic                 wr_valid;

    // x0 never takes a write
    assign wr_valid = wren && (waddr != '0);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_valid) begin
            regs[waddr] <= wdata;
        end
    end

    // same-cycle write is forwarded
    assign rdata1 = (raddr1 == '0) ? '0 :
                    (wr_valid && (waddr == raddr1)) ? wdata : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 :
                    (wr_valid && (waddr == raddr2)) ? wdata : regs[raddr2];

endmodule

//--- hdl/csr_counters.sv
// 64-bit cycle and instret counters with low/high half read decode
`timescale 1ns/1ps
`include "core_regs_defs.svh"

module csr_counters (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 instret_stall,
    csr_access_if.unit           bus,
    output core_regs_pkg::word_t rdata
);

    localparam int CNT_W = 2 * `CORE_XLEN;
    localparam logic [CNT_W-1:0] CNT_ONE = {{(CNT_W-1){1'b0}}, 1'b1};

    logic [CNT_W-1:0] cycle_cnt;
    logic [CNT_W-1:0] instret_cnt;

    // free running
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + CNT_ONE;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            instret_cnt <= '0;
        end else if (!instret_stall) begin
            instret_cnt <= instret_cnt + CNT_ONE;
        end
    end

    always_comb begin
        case (bus.raddr)
            `CSR_CYCLE_ADDR:    rdata = cycle_cnt[`CORE_XLEN-1:0];
            `CSR_CYCLEH_ADDR:   rdata = cycle_cnt[CNT_W-1:`CORE_XLEN];
            `CSR_INSTRET_ADDR:  rdata = instret_cnt[`CORE_XLEN-1:0];
            `CSR_INSTRETH_ADDR: rdata = instret_cnt[CNT_W-1:`CORE_XLEN];
            default:            rdata = '0;
        endcase
    end

endmodule

//--- hdl/csr_trap_ctrl.sv
// mstatus, mie, mip view, mepc, mcause, interrupt arbitration and trap/mret jump
`timescale 1ns/1ps
`include "core_regs_defs.svh"

module csr_trap_ctrl (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 soft_irq,
    input  logic                 time_irq,
    input  logic                 ext_irq,
    input  logic                 iex_valid,
    input  logic                 iex_mret,
    input  logic                 iex_except_valid,
    input  logic [3:0]           iex_except_code,
    input  core_regs_pkg::word_t iex_pc,
    input  core_regs_pkg::word_t iex_next_pc,
    input  core_regs_pkg::word_t mtvec,
    csr_access_if.unit           bus,
    output core_regs_pkg::word_t rdata,
    output logic                 trap_jump_valid,
    output core_regs_pkg::word_t trap_jump_pc
);

    core_regs_pkg::csr_word_u  wr_word;
    core_regs_pkg::mstatus_t   mstatus_view;
    core_regs_pkg::irq_bits_t  mie_q;
    core_regs_pkg::irq_bits_t  mie_wr_val;
    core_regs_pkg::irq_bits_t  mip_view;
    core_regs_pkg::irq_code_e  irq_code;
    core_regs_pkg::word_t      mepc_q;
    core_regs_pkg::word_t      mcause_q;
    core_regs_pkg::word_t      trap_cause;
    logic                      mstatus_mie_q;
    logic                      mstatus_mpie_q;
    logic                      irq_ok;
    logic                      ext_take;
    logic                      soft_take;
    logic                      time_take;
    logic                      irq_take;
    logic                      trap_en;
    logic                      mret_en;

    // one write word, read as mstatus or as interrupt bits by address
    assign wr_word = bus.wdata;

    always_comb begin
        mie_wr_val      = '0;
        mie_wr_val.meip = wr_word.irq.meip;
        mie_wr_val.mtip = wr_word.irq.mtip;
        mie_wr_val.msip = wr_word.irq.msip;
    end

    assign irq_ok    = mstatus_mie_q && iex_valid;
    assign ext_take  = irq_ok && mie_q.meip && ext_irq;
    assign soft_take = irq_ok && mie_q.msip && soft_irq;
    assign time_take = irq_ok && mie_q.mtip && time_irq;
    assign irq_take  = ext_take || soft_take || time_take;
    assign trap_en   = irq_take || iex_except_valid;
    assign mret_en   = iex_valid && iex_mret;

    // external, then software, then timer
    always_comb begin
        if (ext_take) begin
            irq_code = core_regs_pkg::irq_mei;
        end else if (soft_take) begin
            irq_code = core_regs_pkg::irq_msi;
        end else if (time_take) begin
            irq_code = core_regs_pkg::irq_mti;
        end else begin
            irq_code = core_regs_pkg::irq_none;
        end
    end

    // an exception wins over a pending interrupt
    assign trap_cause = iex_except_valid ? {{(`CORE_XLEN-4){1'b0}}, iex_except_code}
                                         : {1'b1, {(`CORE_XLEN-6){1'b0}}, irq_code};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mstatus_mie_q  <= 1'b0;
            mstatus_mpie_q <= 1'b0;
            mie_q          <= '0;
            mepc_q         <= '0;
            mcause_q       <= '0;
        end else begin
            if (trap_en) begin
                mstatus_mpie_q <= mstatus_mie_q;
                mstatus_mie_q  <= 1'b0;
            end else if (mret_en) begin
                mstatus_mie_q  <= mstatus_mpie_q;
                mstatus_mpie_q <= 1'b1;
            end else if (bus.wren && (bus.waddr == `CSR_MSTATUS_ADDR)) begin
                mstatus_mie_q  <= wr_word.mstatus.mie;
                mstatus_mpie_q <= wr_word.mstatus.mpie;
            end
            if (bus.wren && (bus.waddr == `CSR_MIE_ADDR)) begin
                mie_q <= mie_wr_val;
            end
            if (trap_en) begin
                mepc_q <= iex_except_valid ? iex_pc : iex_next_pc;
            end else if (bus.wren && (bus.waddr == `CSR_MEPC_ADDR)) begin
                mepc_q <= bus.wdata;
            end
            if (trap_en) begin
                mcause_q <= trap_cause;
            end else if (bus.wren && (bus.waddr == `CSR_MCAUSE_ADDR)) begin
                mcause_q <= bus.wdata;
            end
        end
    end

    always_comb begin
        mstatus_view      = '0;
        mstatus_view.mpp  = 2'b11;
        mstatus_view.mpie = mstatus_mpie_q;
        mstatus_view.mie  = mstatus_mie_q;
        mip_view          = '0;
        mip_view.meip     = ext_irq;
        mip_view.mtip     = time_irq;
        mip_view.msip     = soft_irq;
    end

    always_comb begin
        case (bus.raddr)
            `CSR_MSTATUS_ADDR: rdata = mstatus_view;
            `CSR_MIE_ADDR:     rdata = mie_q;
            `CSR_MIP_ADDR:     rdata = mip_view;
            `CSR_MEPC_ADDR:    rdata = mepc_q;
            `CSR_MCAUSE_ADDR:  rdata = mcause_q;
            default:           rdata = '0;
        endcase
    end

    assign trap_jump_valid = trap_en || mret_en;
    assign trap_jump_pc    = trap_en ? {mtvec[`CORE_XLEN-1:2], 2'b00} : mepc_q;

endmodule

//--- hdl/csr_file.sv
// machine CSR file: mtvec, mscratch, sub-unit instances, read merge and write bypass
`timescale 1ns/1ps
`include "core_regs_defs.svh"

module csr_file (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      wren,
    input  core_regs_pkg::csr_addr_t  waddr,
    input  core_regs_pkg::csr_addr_t  raddr,
    input  core_regs_pkg::word_t      wdata,
    input  logic                      instret_stall,
    input  logic                      soft_irq,
    input  logic                      time_irq,
    input  logic                      ext_irq,
    input  logic                      iex_valid,
    input  logic                      iex_mret,
    input  logic                      iex_except_valid,
    input  logic [3:0]                iex_except_code,
    input  core_regs_pkg::word_t      iex_pc,
    input  core_regs_pkg::word_t      iex_next_pc,
    output core_regs_pkg::word_t      rdata,
    output logic                      trap_jump_valid,
    output core_regs_pkg::word_t      trap_jump_pc
);

    core_regs_pkg::word_t mtvec_q;
    core_regs_pkg::word_t mscratch_q;
    core_regs_pkg::word_t local_rdata;
    core_regs_pkg::word_t cnt_rdata;
    core_regs_pkg::word_t trap_rdata;

    csr_access_if bus ();

    assign bus.wren  = wren;
    assign bus.waddr = waddr;
    assign bus.wdata = wdata;
    assign bus.raddr = raddr;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mtvec_q    <= '0;
            mscratch_q <= '0;
        end else if (wren) begin
            if (waddr == `CSR_MTVEC_ADDR) begin
                mtvec_q <= wdata;
            end
            if (waddr == `CSR_MSCRATCH_ADDR) begin
                mscratch_q <= wdata;
            end
        end
    end

    assign local_rdata = (raddr == `CSR_MTVEC_ADDR)    ? mtvec_q :
                         (raddr == `CSR_MSCRATCH_ADDR) ? mscratch_q : '0;

    csr_counters i_csr_counters (
        .clk           (clk),
        .rstn          (rstn),
        .instret_stall (instret_stall),
        .bus           (bus.unit),
        .rdata         (cnt_rdata)
    );

    csr_trap_ctrl i_csr_trap_ctrl (
        .clk              (clk),
        .rstn             (rstn),
        .soft_irq         (soft_irq),
        .time_irq         (time_irq),
        .ext_irq          (ext_irq),
        .iex_valid        (iex_valid),
        .iex_mret         (iex_mret),
        .iex_except_valid (iex_except_valid),
        .iex_except_code  (iex_except_code),
        .iex_pc           (iex_pc),
        .iex_next_pc      (iex_next_pc),
        .mtvec            (mtvec_q),
        .bus              (bus.unit),
        .rdata            (trap_rdata),
        .trap_jump_valid  (trap_jump_valid),
        .trap_jump_pc     (trap_jump_pc)
    );

    // unowned addresses read zero from every unit, so OR is the merge
    assign rdata = (wren && (raddr == waddr)) ? wdata
                                              : (local_rdata | cnt_rdata | trap_rdata);

endmodule

//--- hdl/core_regs_top.sv
// core register block top level: integer register file and machine CSR file
`timescale 1ns/1ps

module core_regs_top (
    input  logic                      clk,
    input  logic                      rstn,
    // register file
    input  logic                      gpr_wren,
    input  core_regs_pkg::gpr_addr_t  gpr_waddr,
    input  core_regs_pkg::word_t      gpr_wdata,
    input  core_regs_pkg::gpr_addr_t  gpr_raddr1,
    input  core_regs_pkg::gpr_addr_t  gpr_raddr2,
    output core_regs_pkg::word_t      gpr_rdata1,
    output core_regs_pkg::word_t      gpr_rdata2,
    // CSR access
    input  logic                      csr_wren,
    input  core_regs_pkg::csr_addr_t  csr_waddr,
    input  core_regs_pkg::word_t      csr_wdata,
    input  core_regs_pkg::csr_addr_t  csr_raddr,
    output core_regs_pkg::word_t      csr_rdata,
    input  logic                      instret_stall,
    // interrupt lines
    input  logic                      soft_irq,
    input  logic                      time_irq,
    input  logic                      ext_irq,
    // execute stage
    input  logic                      iex_valid,
    input  logic                      iex_mret,
    input  logic                      iex_except_valid,
    input  logic [3:0]                iex_except_code,
    input  core_regs_pkg::word_t      iex_pc,
    input  core_regs_pkg::word_t      iex_next_pc,
    // redirect to fetch
    output logic                      trap_jump_valid,
    output core_regs_pkg::word_t      trap_jump_pc
);

    gpr_file i_gpr_file (
        .clk    (clk),
        .rstn   (rstn),
        .wren   (gpr_wren),
        .waddr  (gpr_waddr),
        .wdata  (gpr_wdata),
        .raddr1 (gpr_raddr1),
        .raddr2 (gpr_raddr2),
        .rdata1 (gpr_rdata1),
        .rdata2 (gpr_rdata2)
    );

    csr_file i_csr_file (
        .clk              (clk),
        .rstn             (rstn),
        .wren             (csr_wren),
        .waddr            (csr_waddr),
        .raddr            (csr_raddr),
        .wdata            (csr_wdata),
        .instret_stall    (instret_stall),
        .soft_irq         (soft_irq),
        .time_irq         (time_irq),
        .ext_irq          (ext_irq),
        .iex_valid        (iex_valid),
        .iex_mret         (iex_mret),
        .iex_except_valid (iex_except_valid),
        .iex_except_code  (iex_except_code),
        .iex_pc           (iex_pc),
        .iex_next_pc      (iex_next_pc),
        .rdata            (csr_rdata),
        .trap_jump_valid  (trap_jump_valid),
        .trap_jump_pc     (trap_jump_pc)
    );

endmodule

//--- verif/core_regs_checker.sv
// concurrent assertions on core_regs_top: trap gating, x0 reads, exception cause type
`timescale 1ns/1ps

module core_regs_checker (
    input logic                 clk,
    input logic                 rstn,
    input logic                 trap_jump_valid,
    input logic                 iex_valid,
    input logic                 iex_mret,
    input logic                 iex_except_valid,
    input logic                 mstatus_mie,
    input core_regs_pkg::word_t mcause,
    input core_regs_pkg::gpr_addr_t gpr_raddr1,
    input core_regs_pkg::gpr_addr_t gpr_raddr2,
    input core_regs_pkg::word_t gpr_rdata1,
    input core_regs_pkg::word_t gpr_rdata2
);

    // failed assertions so far
    int assert_fails = 0;

    // interrupts need MIE, exceptions and mret do not
    trap_needs_mie: assert property (@(posedge clk) disable iff (!rstn)
        trap_jump_valid |-> (mstatus_mie || iex_except_valid || (iex_valid && iex_mret)))
        else begin
            $error("trap jump with MIE clear and no exception or mret");
            assert_fails++;
        end

    x0_read1_zero: assert property (@(posedge clk) disable iff (!rstn)
        (gpr_raddr1 == '0) |-> (gpr_rdata1 == '0))
        else begin
            $error("read port 1 returned nonzero for x0");
            assert_fails++;
        end

    x0_read2_zero: assert property (@(posedge clk) disable iff (!rstn)
        (gpr_raddr2 == '0) |-> (gpr_rdata2 == '0))
        else begin
            $error("read port 2 returned nonzero for x0");
            assert_fails++;
        end

    // exceptions carry a clear interrupt flag
    except_cause_flag: assert property (@(posedge clk) disable iff (!rstn)
        (trap_jump_valid && iex_except_valid) |=> !mcause[31])
        else begin
            $error("mcause interrupt flag set after an exception trap");
            assert_fails++;
        end

endmodule

bind core_regs_top core_regs_checker i_core_regs_checker (
    .clk              (clk),
    .rstn             (rstn),
    .trap_jump_valid  (trap_jump_valid),
    .iex_valid        (iex_valid),
    .iex_mret         (iex_mret),
    .iex_except_valid (iex_except_valid),
    .mstatus_mie      (i_csr_file.i_csr_trap_ctrl.mstatus_mie_q),
    .mcause           (i_csr_file.i_csr_trap_ctrl.mcause_q),
    .gpr_raddr1       (gpr_raddr1),
    .gpr_raddr2       (gpr_raddr2),
    .gpr_rdata1       (gpr_rdata1),
    .gpr_rdata2       (gpr_rdata2)
);

//--- verif/core_regs_tb.sv
// testbench for core_regs_top: clock, reset, stimulus reader, reference model, checks, summary
`timescale 1ns/1ps
`include "core_regs_defs.svh"

module core_regs_tb;

    localparam string STIM_FILE = "verif/core_regs_stimulus.txt";

    localparam logic [47:0] OP_GPR   = {24'd0, "gpr"};
    localparam logic [47:0] OP_CSR   = {24'd0, "csr"};
    localparam logic [47:0] OP_TRAP  = {16'd0, "trap"};
    localparam logic [47:0] OP_MRET  = {16'd0, "mret"};
    localparam logic [47:0] OP_IRQ   = {24'd0, "irq"};
    localparam logic [47:0] OP_COUNT = {8'd0, "count"};
    localparam logic [47:0] OP_NOTE  = {40'd0, "#"};

    logic                      clk;
    logic                      rstn;
    logic                      gpr_wren;
    core_regs_pkg::gpr_addr_t  gpr_waddr;
    core_regs_pkg::word_t      gpr_wdata;
    core_regs_pkg::gpr_addr_t  gpr_raddr1;
    core_regs_pkg::gpr_addr_t  gpr_raddr2;
    core_regs_pkg::word_t      gpr_rdata1;
    core_regs_pkg::word_t      gpr_rdata2;
    logic                      csr_wren;
    core_regs_pkg::csr_addr_t  csr_waddr;
    core_regs_pkg::word_t      csr_wdata;
    core_regs_pkg::csr_addr_t  csr_raddr;
    core_regs_pkg::word_t      csr_rdata;
    logic                      instret_stall;
    logic                      soft_irq;
    logic                      time_irq;
    logic                      ext_irq;
    logic                      iex_valid;
    logic                      iex_mret;
    logic                      iex_except_valid;
    logic [3:0]                iex_except_code;
    core_regs_pkg::word_t      iex_pc;
    core_regs_pkg::word_t      iex_next_pc;
    logic                      trap_jump_valid;
    core_regs_pkg::word_t      trap_jump_pc;

    // parsed stimulus lines
    logic [47:0]          op_q [$];
    core_regs_pkg::word_t a_q [$];
    core_regs_pkg::word_t b_q [$];
    core_regs_pkg::word_t c_q [$];
    core_regs_pkg::word_t exp_q [$];
    int                   line_q [$];

    // reference model state
    core_regs_pkg::word_t gpr_model [32];
    core_regs_pkg::word_t mtvec_model;
    logic                 mie_model;
    logic                 mpie_model;

    int test_errors;
    int tests_failed = 0;
    int stim_errors = 0;
    int cycle_count = 0;
    int cycle_limit = 1000;

    core_regs_top i_core_regs_top (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic check_word(input string name, input core_regs_pkg::word_t exp,
                              input core_regs_pkg::word_t act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %08h, got %08h", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED at %0t: %s expected %b, got %b", $time, name, exp, act);
            test_errors++;
        end
    endtask

    task automatic read_csr(input core_regs_pkg::csr_addr_t addr,
                            output core_regs_pkg::word_t val);
        csr_raddr = addr;
        #2;
        val = csr_rdata;
    endtask

    function automatic core_regs_pkg::word_t mstatus_expect(input logic mie, input logic mpie);
        return {19'd0, 2'b11, 3'd0, mpie, 3'd0, mie, 3'd0};
    endfunction

    task automatic load_stimulus(output logic ok);
        int                   fd;
        int                   n;
        int                   line_no;
        logic [8*120-1:0]     line_buf;
        logic [47:0]          op;
        core_regs_pkg::word_t a;
        core_regs_pkg::word_t b;
        core_regs_pkg::word_t c;
        core_regs_pkg::word_t e;
        ok = 1'b0;
        line_no = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd != 0) begin
            ok = 1'b1;
            while (!$feof(fd)) begin
                line_buf = '0;
                n = $fgets(line_buf, fd);
                line_no++;
                if (n > 0) begin
                    op = '0;
                    n = $sscanf(line_buf, "%s %h %h %h %h", op, a, b, c, e);
                    if (n == 5 && op != OP_NOTE) begin
                        op_q.push_back(op);
                        a_q.push_back(a);
                        b_q.push_back(b);
                        c_q.push_back(c);
                        exp_q.push_back(e);
                        line_q.push_back(line_no);
                    end else if (n > 0 && op != OP_NOTE) begin
                        $display("stimulus line %0d has too few fields", line_no);
                        stim_errors++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int idx);
        logic [47:0]              op;
        string                    name;
        core_regs_pkg::word_t     a;
        core_regs_pkg::word_t     b;
        core_regs_pkg::word_t     c;
        core_regs_pkg::word_t     e;
        core_regs_pkg::word_t     act;
        core_regs_pkg::word_t     data;
        core_regs_pkg::word_t     rnd;
        core_regs_pkg::word_t     cnt0;
        core_regs_pkg::word_t     cnt1;
        core_regs_pkg::word_t     ins0;
        core_regs_pkg::word_t     ins1;
        core_regs_pkg::gpr_addr_t gidx;
        int                       k;
        op = op_q[idx];
        a = a_q[idx];
        b = b_q[idx];
        c = c_q[idx];
        e = exp_q[idx];
        test_errors = 0;
        @(negedge clk);
        case (op)
            OP_GPR: begin
                name = "gpr";
                if (c[0]) begin
                    rnd = $urandom % 31;
                    gidx = rnd[4:0] + 5'd1;
                    data = $urandom;
                end else begin
                    gidx = a[4:0];
                    data = b;
                end
                gpr_wren = 1'b1;
                gpr_waddr = gidx;
                gpr_wdata = data;
                gpr_raddr1 = gidx;
                #2;
                // same-cycle read sees the write, except x0
                check_word("gpr_rdata1", (gidx == 5'd0) ? 32'd0 : data, gpr_rdata1);
                if (gidx != 5'd0) begin
                    gpr_model[gidx] = data;
                end
                @(negedge clk);
                gpr_wren = 1'b0;
                gpr_raddr2 = gidx;
                #2;
                check_word("gpr_rdata2", c[0] ? gpr_model[gidx] : e, gpr_rdata2);
            end
            OP_CSR: begin
                name = "csr";
                if (c[0]) begin
                    csr_wren = 1'b1;
                    csr_waddr = a[11:0];
                    csr_wdata = b;
                    read_csr(a[11:0], act);
                    check_word("csr_rdata", b, act);
                    if (a[11:0] == `CSR_MTVEC_ADDR) begin
                        mtvec_model = b;
                    end
                    if (a[11:0] == `CSR_MSTATUS_ADDR) begin
                        mie_model = b[3];
                        mpie_model = b[7];
                    end
                    @(negedge clk);
                    csr_wren = 1'b0;
                end
                read_csr(a[11:0], act);
                check_word("csr_rdata", e, act);
            end
            OP_TRAP: begin
                name = "trap";
                iex_valid = 1'b1;
                iex_except_valid = 1'b1;
                iex_except_code = a[3:0];
                iex_pc = b;
                iex_next_pc = b + 32'd4;
                #2;
                check_bit("trap_jump_valid", 1'b1, trap_jump_valid);
                check_word("trap_jump_pc", e, trap_jump_pc);
                @(negedge clk);
                iex_valid = 1'b0;
                iex_except_valid = 1'b0;
                mpie_model = mie_model;
                mie_model = 1'b0;
                read_csr(`CSR_MEPC_ADDR, act);
                check_word("mepc", b, act);
                read_csr(`CSR_MCAUSE_ADDR, act);
                check_word("mcause", {28'd0, a[3:0]}, act);
                read_csr(`CSR_MSTATUS_ADDR, act);
                check_word("mstatus", mstatus_expect(mie_model, mpie_model), act);
            end
            OP_MRET: begin
                name = "mret";
                iex_valid = 1'b1;
                iex_mret = 1'b1;
                #2;
                check_bit("trap_jump_valid", 1'b1, trap_jump_valid);
                check_word("trap_jump_pc", e, trap_jump_pc);
                @(negedge clk);
                iex_valid = 1'b0;
                iex_mret = 1'b0;
                mie_model = mpie_model;
                mpie_model = 1'b1;
                read_csr(`CSR_MSTATUS_ADDR, act);
                check_word("mstatus", mstatus_expect(mie_model, mpie_model), act);
            end
            OP_IRQ: begin
                name = "irq";
                soft_irq = a[3];
                time_irq = a[7];
                ext_irq = a[11];
                iex_valid = b[0];
                iex_pc = 32'h200;
                iex_next_pc = 32'h204;
                read_csr(`CSR_MIP_ADDR, act);
                check_word("mip", a & 32'h888, act);
                check_bit("trap_jump_valid", e != 32'd0, trap_jump_valid);
                if (e != 32'd0) begin
                    check_word("trap_jump_pc", {mtvec_model[31:2], 2'b00}, trap_jump_pc);
                end
                @(negedge clk);
                soft_irq = 1'b0;
                time_irq = 1'b0;
                ext_irq = 1'b0;
                iex_valid = 1'b0;
                if (e != 32'd0) begin
                    mpie_model = mie_model;
                    mie_model = 1'b0;
                    read_csr(`CSR_MCAUSE_ADDR, act);
                    check_word("mcause", e, act);
                    read_csr(`CSR_MEPC_ADDR, act);
                    check_word("mepc", 32'h204, act);
                    read_csr(`CSR_MSTATUS_ADDR, act);
                    check_word("mstatus", mstatus_expect(mie_model, mpie_model), act);
                end
            end
            OP_COUNT: begin
                name = "count";
                read_csr(`CSR_CYCLE_ADDR, cnt0);
                read_csr(`CSR_INSTRET_ADDR, ins0);
                // one stall bit per rising edge
                for (k = 0; k < a; k++) begin
                    instret_stall = b[k];
                    @(negedge clk);
                end
                instret_stall = 1'b0;
                read_csr(`CSR_CYCLE_ADDR, cnt1);
                read_csr(`CSR_INSTRET_ADDR, ins1);
                check_word("cycle delta", a, cnt1 - cnt0);
                check_word("instret delta", e, ins1 - ins0);
                read_csr(`CSR_CYCLEH_ADDR, act);
                check_word("cycleh", 32'd0, act);
                read_csr(`CSR_INSTRETH_ADDR, act);
                check_word("instreth", 32'd0, act);
            end
            default: begin
                name = "unknown";
                $display("stimulus line %0d has an unknown opcode", line_q[idx]);
                test_errors++;
            end
        endcase
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %0d (line %0d) %s: %s", idx, line_q[idx], name,
                 (test_errors == 0) ? "ok" : "failed");
    endtask

    initial begin
        logic loaded;
        int   i;
        void'($urandom(34532));
        rstn = 1'b0;
        gpr_wren = 1'b0;
        gpr_waddr = '0;
        gpr_wdata = '0;
        gpr_raddr1 = '0;
        gpr_raddr2 = '0;
        csr_wren = 1'b0;
        csr_waddr = '0;
        csr_wdata = '0;
        csr_raddr = '0;
        instret_stall = 1'b0;
        soft_irq = 1'b0;
        time_irq = 1'b0;
        ext_irq = 1'b0;
        iex_valid = 1'b0;
        iex_mret = 1'b0;
        iex_except_valid = 1'b0;
        iex_except_code = '0;
        iex_pc = '0;
        iex_next_pc = '0;
        for (i = 0; i < 32; i++) begin
            gpr_model[i] = '0;
        end
        mtvec_model = '0;
        mie_model = 1'b0;
        mpie_model = 1'b0;
        load_stimulus(loaded);
        cycle_limit = op_q.size() * 8 + 20;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        if (!loaded) begin
            $display("stimulus file %s could not be opened", STIM_FILE);
            $display("STATUS: FAIL");
        end else begin
            for (i = 0; i < op_q.size(); i++) begin
                run_test(i);
            end
            $display("tests run %0d, failed %0d, unreadable stimulus lines %0d, %s %0d",
                     op_q.size(), tests_failed, stim_errors, "assertion failures",
                     i_core_regs_top.i_core_regs_checker.assert_fails);
            if (tests_failed == 0 && stim_errors == 0 && op_q.size() > 0 &&
                i_core_regs_top.i_core_regs_checker.assert_fails == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
        end
        $finish;
    end

endmodule

//--- verif/core_regs_stimulus.txt
# op a b c expected, all hex; gpr: index data random | csr: address data write
# trap: code pc - target | mret: - - - target | irq: lines valid - mcause | count: n stalls -
gpr   05  12345678 0 12345678
gpr   1f  cafef00d 0 cafef00d
gpr   00  deadbeef 0 00000000
gpr   00  00000000 1 00000000
gpr   00  00000000 1 00000000
gpr   00  00000000 1 00000000
csr   340 a5a5a5a5 1 a5a5a5a5
csr   305 00001003 1 00001003
csr   304 ffffffff 1 00000888
csr   301 12345678 1 00000000
csr   344 00000000 0 00000000
csr   300 ffffffff 1 00001888
trap  2   00000400 0 00001000
mret  0   00000000 0 00000400
irq   888 00000001 0 8000000b
mret  0   00000000 0 00000204
irq   088 00000001 0 80000003
mret  0   00000000 0 00000204
irq   080 00000001 0 80000007
mret  0   00000000 0 00000204
irq   888 00000000 0 00000000
csr   300 00000000 1 00001800
irq   888 00000001 0 00000000
csr   300 00000008 1 00001808
csr   304 00000080 1 00000080
irq   808 00000001 0 00000000
trap  5   00000800 0 00001000
mret  0   00000000 0 00000800
count 5   00000000 0 00000005
count 6   00000015 0 00000003
count 7   0000007f 0 00000000

//--- tb.f
+incdir+hdl
hdl/core_regs_pkg.sv
hdl/csr_access_if.sv
hdl/gpr_file.sv
hdl/csr_counters.sv
hdl/csr_trap_ctrl.sv
hdl/csr_file.sv
hdl/core_regs_top.sv
verif/core_regs_checker.sv
verif/core_regs_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module core_regs_tb -f tb.f -o core_regs_sim \
    && ./obj_dir/core_regs_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "STATUS: PASS" sim.log 2>/dev/null && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
